// ==== src.f ====
+incdir+tb
hdl/accel_cfg_pkg.sv
hdl/accel_map_pkg.sv
hdl/thread_slot_counter.sv
hdl/multiplier_pipeline.sv
hdl/accumulator_bank.sv
hdl/octavo_accel.sv
tb/tb_octavo_accel.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_octavo_accel
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_octavo_accel_tasks.svh ====
// Slot stepping, driving, checks and the directed tests.
// Every drive task updates the model for the thread owning the slot.

// ----------------------------------------------------------------------
// Slot stepping and drive helpers

task automatic set_idle();
    rb            = '0;
    write_addr_rb = NULL_WRITE_ADDR;
    mul_a         = '0;
    mul_a_wren    = 1'b0;
    mul_b         = '0;
    mul_b_wren    = 1'b0;
    acc_addend    = '0;
    acc_write     = 1'b0;
    acc_read      = 1'b0;
endtask

// Holds rst for two cycles and releases it on a falling edge
task automatic apply_reset();
    rst = 1'b1;
    set_idle();
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
endtask

task automatic step();
    @(negedge clock);
    set_idle();
endtask

// Always advances at least one slot
task automatic goto_slot(input thread_t t);
    step();
    while (cur_thread() != t) begin
        step();
    end
endtask

task automatic write_operands(input logic a_wr, input word_t a,
                              input logic b_wr, input word_t b);
    thread_t t;
    t          = cur_thread();
    mul_a      = a;
    mul_a_wren = a_wr;
    mul_b      = b;
    mul_b_wren = b_wr;
    if (a_wr) begin
        model_a[t] = a;
    end
    if (b_wr) begin
        model_b[t] = b;
    end
endtask

task automatic write_mode(input logic sgn);
    write_addr_rb             = MUL_CONFIG_ADDR;
    rb                        = {{(WORD_WIDTH-1){1'b0}}, sgn};
    model_signed[cur_thread()] = sgn;
endtask

task automatic acc_access(input logic wr, input word_t addend, input logic rd);
    thread_t t;
    t          = cur_thread();
    acc_write  = wr;
    acc_addend = addend;
    acc_read   = rd;
    if (rd && wr) begin
        model_total[t] = addend;
    end else if (rd) begin
        model_total[t] = '0;
    end else if (wr) begin
        model_total[t] = model_total[t] + addend;
    end
endtask

// ----------------------------------------------------------------------
// Checks and reporting

task automatic check_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
        $display("ERROR %s thread %0d: expected %h, got %h",
                 name, cur_thread(), expected, actual);
        test_errors++;
    end
endtask

task automatic check_slot();
    thread_t  t;
    product_t p;
    t = cur_thread();
    p = expected_product(model_a[t], model_b[t], model_signed[t]);
    check_word("mul_r_low", p[WORD_WIDTH-1:0], mul_r_low);
    check_word("mul_r_high", p[2*WORD_WIDTH-1:WORD_WIDTH], mul_r_high);
    check_word("acc_total", model_total[t], acc_total);
endtask

task automatic finish_test(input string name);
    if (test_errors == 0) begin
        pass_count++;
        $display("[ok]   %s", name);
    end else begin
        fail_count++;
        $display("[FAIL] %s, %0d mismatches", name, test_errors);
    end
    test_errors = 0;
endtask

// ----------------------------------------------------------------------
// Directed tests

// Every thread first gets nonzero operands, signed mode and a nonzero
// total, so the second reset has state to clear
task automatic test_reset_state();
    for (int i = 0; i < 2 * THREAD_COUNT; i++) begin
        step();
        mul_a         = 36'h7FFFFFFFF;
        mul_a_wren    = 1'b1;
        mul_b         = 36'h7FFFFFFFF;
        mul_b_wren    = 1'b1;
        write_addr_rb = MUL_CONFIG_ADDR;
        rb            = 36'h1;
        acc_addend    = 36'h123456789;
        acc_write     = 1'b1;
    end
    step();
    apply_reset();
    for (int i = 0; i < THREAD_COUNT; i++) begin
        if (i > 0) begin
            step();
        end
        check_word("mul_r_low", '0, mul_r_low);
        check_word("mul_r_high", '0, mul_r_high);
        check_word("acc_total", '0, acc_total);
    end
    finish_test("reset state");
endtask

task automatic test_unsigned_multiply();
    goto_slot(thread_t'(2));
    write_operands(1'b1, 36'hFEDCBA987, 1'b1, 36'h9ABCDEF01);
    goto_slot(thread_t'(2));
    check_slot();
    assert (mul_r_high != '0) else begin
        $display("Unsigned product has a zero high word, the operands are too small");
        test_errors++;
    end
    finish_test("unsigned multiply");
endtask

// Thread 5 signed, thread 6 unsigned, same operands (-7 and a large negative)
task automatic test_signed_mode();
    word_t neg_a;
    word_t neg_b;
    neg_a = 36'hFFFFFFFF9;
    neg_b = 36'h800000123;
    goto_slot(thread_t'(5));
    write_mode(1'b1);
    write_operands(1'b1, neg_a, 1'b1, neg_b);
    goto_slot(thread_t'(6));
    write_operands(1'b1, neg_a, 1'b1, neg_b);
    goto_slot(thread_t'(5));
    check_slot();
    write_mode(1'b0);
    goto_slot(thread_t'(6));
    check_slot();
    goto_slot(thread_t'(5));
    check_slot();
    finish_test("signed mode per thread");
endtask

task automatic test_interleaved_threads();
    word_t x;
    word_t y;
    for (int i = 0; i < THREAD_COUNT; i++) begin
        goto_slot(thread_t'(i));
        check_slot();
        x = lcg_word();
        y = lcg_word();
        write_operands(1'b1, x, 1'b1, y);
    end
    // Even threads rewrite only A, odd threads only B
    for (int i = 0; i < THREAD_COUNT; i++) begin
        goto_slot(thread_t'(i));
        check_slot();
        x = lcg_word();
        write_operands(i % 2 == 0, x, i % 2 == 1, x);
    end
    for (int i = 0; i < THREAD_COUNT; i++) begin
        goto_slot(thread_t'(i));
        check_slot();
    end
    finish_test("interleaved threads");
endtask

task automatic test_accumulator();
    for (int n = 0; n < 3 * THREAD_COUNT; n++) begin
        goto_slot(thread_t'(n % THREAD_COUNT));
        check_slot();
        acc_access(1'b1, lcg_word(), 1'b0);
    end
    for (int i = 0; i < THREAD_COUNT; i++) begin
        goto_slot(thread_t'(i));
        check_slot();
        acc_access(1'b0, '0, 1'b1);
    end
    // Cleared totals, then read together with write
    for (int i = 0; i < THREAD_COUNT; i++) begin
        goto_slot(thread_t'(i));
        check_slot();
        acc_access(1'b1, lcg_word(), 1'b1);
    end
    for (int i = 0; i < THREAD_COUNT; i++) begin
        goto_slot(thread_t'(i));
        check_slot();
    end
    finish_test("accumulator");
endtask

// ==== tb/tb_octavo_accel.sv ====
// Directed testbench for octavo_accel. Inputs change on the falling edge,
// outputs are sampled on that same edge before the slot's writes are driven.
`timescale 1ns/1ps

module tb_octavo_accel;

    import accel_cfg_pkg::*;
    import accel_map_pkg::*;

    // The test sequence runs under 200 cycles
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [63:0] LCG_SEED       = 64'd68;

    logic        clock;
    logic        rst;
    word_t       rb;
    write_addr_t write_addr_rb;
    word_t       mul_a;
    logic        mul_a_wren;
    word_t       mul_b;
    logic        mul_b_wren;
    word_t       acc_addend;
    logic        acc_write;
    logic        acc_read;
    word_t       mul_r_low;
    word_t       mul_r_high;
    word_t       acc_total;

    // Reference model, one entry per thread
    word_t       model_a      [THREAD_COUNT];
    word_t       model_b      [THREAD_COUNT];
    logic        model_signed [THREAD_COUNT];
    word_t       model_total  [THREAD_COUNT];

    logic [63:0] lcg_state;
    int          slot_count;
    int          watchdog_cycles;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    octavo_accel uut (
        .clock         (clock),
        .rst           (rst),
        .rb            (rb),
        .write_addr_rb (write_addr_rb),
        .mul_a         (mul_a),
        .mul_a_wren    (mul_a_wren),
        .mul_b         (mul_b),
        .mul_b_wren    (mul_b_wren),
        .acc_addend    (acc_addend),
        .acc_write     (acc_write),
        .acc_read      (acc_read),
        .mul_r_low     (mul_r_low),
        .mul_r_high    (mul_r_high),
        .acc_total     (acc_total)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Cycles since reset release, thread = count mod 8
    always @(posedge clock) begin
        if (rst) begin
            slot_count <= 0;
        end else begin
            slot_count <= slot_count + 1;
        end
    end

    always @(posedge clock) begin
        watchdog_cycles <= watchdog_cycles + 1;
        if (watchdog_cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not finish in %0d cycles",
                     TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Model helpers

    function automatic word_t lcg_word();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:28];
    endfunction

    // Signed product from the unsigned one, minus 2^36 times each
    // operand whose partner is negative
    function automatic product_t expected_product(input word_t a, input word_t b,
                                                  input logic sgn);
        product_t p;
        p = {{WORD_WIDTH{1'b0}}, a} * {{WORD_WIDTH{1'b0}}, b};
        if (sgn && a[WORD_WIDTH-1]) begin
            p = p - {b, {WORD_WIDTH{1'b0}}};
        end
        if (sgn && b[WORD_WIDTH-1]) begin
            p = p - {a, {WORD_WIDTH{1'b0}}};
        end
        return p;
    endfunction

    function automatic thread_t cur_thread();
        return thread_t'(slot_count % THREAD_COUNT);
    endfunction

    `include "tb_octavo_accel_tasks.svh"

    initial begin
        watchdog_cycles = 0;
        lcg_state       = LCG_SEED;
        test_errors     = 0;
        pass_count      = 0;
        fail_count      = 0;
        for (int i = 0; i < THREAD_COUNT; i++) begin
            model_a[i]      = '0;
            model_b[i]      = '0;
            model_signed[i] = 1'b0;
            model_total[i]  = '0;
        end
        apply_reset();

        test_reset_state();
        test_unsigned_multiply();
        test_signed_mode();
        test_interleaved_threads();
        test_accumulator();

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/octavo_accel.sv ====
// Accelerator slice of the CPU I/O ports, without the core itself.
// All inputs belong to the thread that owns the current cycle.
`timescale 1ns/1ps

module octavo_accel (
    input  logic                       clock,
    input  logic                       rst,
    input  accel_cfg_pkg::word_t       rb,
    input  accel_map_pkg::write_addr_t write_addr_rb,
    input  accel_cfg_pkg::word_t       mul_a,
    input  logic                       mul_a_wren,
    input  accel_cfg_pkg::word_t       mul_b,
    input  logic                       mul_b_wren,
    input  accel_cfg_pkg::word_t       acc_addend,
    input  logic                       acc_write,
    input  logic                       acc_read,
    output accel_cfg_pkg::word_t       mul_r_low,
    output accel_cfg_pkg::word_t       mul_r_high,
    output accel_cfg_pkg::word_t       acc_total
);

    import accel_cfg_pkg::*;

    thread_t thread;

    // ------------------------------------------------------------------
    // Thread rotation shared by both accelerators

    thread_slot_counter slot_counter (
        .clock  (clock),
        .rst    (rst),
        .thread (thread)
    );

    // ------------------------------------------------------------------
    // Multiplier on port A slot 0 and port B slot 0
    // Rb bit 0 selects signed mode, 0 is unsigned

    multiplier_pipeline multiplier (
        .clock         (clock),
        .rst           (rst),
        .thread        (thread),
        .config_addr   (write_addr_rb),
        .config_signed (rb[0]),
        .a             (mul_a),
        .a_wren        (mul_a_wren),
        .b             (mul_b),
        .b_wren        (mul_b_wren),
        .r_low         (mul_r_low),
        .r_high        (mul_r_high)
    );

    // ------------------------------------------------------------------
    // Accumulator on port A slot 1

    accumulator_bank accumulator (
        .clock        (clock),
        .rst          (rst),
        .thread       (thread),
        .addend       (acc_addend),
        .write_addend (acc_write),
        .read_total   (acc_read),
        .total        (acc_total)
    );

endmodule

// ==== hdl/accumulator_bank.sv ====
// One running total per thread, wrapping modulo 2^WORD_WIDTH.
// A read clears the total after it has been shown in that slot.
`timescale 1ns/1ps

module accumulator_bank (
    input  logic                   clock,
    input  logic                   rst,
    input  accel_cfg_pkg::thread_t thread,
    input  accel_cfg_pkg::word_t   addend,
    input  logic                   write_addend,
    input  logic                   read_total,
    output accel_cfg_pkg::word_t   total
);

    import accel_cfg_pkg::*;

    word_t totals [THREAD_COUNT];

    // Current thread sees its own total without delay
    assign total = totals[thread];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                totals[i] <= '0;
            end
        end else begin
            case ({read_total, write_addend})
                2'b11: begin
                    // Clear and add in the same slot
                    totals[thread] <= addend;
                end
                2'b10: begin
                    totals[thread] <= '0;
                end
                2'b01: begin
                    totals[thread] <= totals[thread] + addend;
                end
                default: begin
                    totals[thread] <= totals[thread];
                end
            endcase
        end
    end

endmodule

// ==== hdl/multiplier_pipeline.sv ====
// Per-thread signed/unsigned multiplier. A product appears in the writing
// thread's next slot. Every thread is recomputed once per rotation, so a
// result holds while its operands and mode stay unchanged.
`timescale 1ns/1ps

module multiplier_pipeline (
    input  logic                       clock,
    input  logic                       rst,
    input  accel_cfg_pkg::thread_t     thread,
    input  accel_map_pkg::write_addr_t config_addr,
    input  logic                       config_signed,
    input  accel_cfg_pkg::word_t       a,
    input  logic                       a_wren,
    input  accel_cfg_pkg::word_t       b,
    input  logic                       b_wren,
    output accel_cfg_pkg::word_t       r_low,
    output accel_cfg_pkg::word_t       r_high
);

    import accel_cfg_pkg::*;
    import accel_map_pkg::*;

    // ------------------------------------------------------------------
    // Per-thread stores

    word_t    a_store      [THREAD_COUNT];
    word_t    b_store      [THREAD_COUNT];
    logic     signed_store [THREAD_COUNT];
    word_t    low_store    [THREAD_COUNT];
    word_t    high_store   [THREAD_COUNT];

    // ------------------------------------------------------------------
    // Pipeline state

    thread_t  read_thread;
    logic     config_match;
    word_t    s1_a;
    word_t    s1_b;
    logic     s1_signed;
    product_t s1_a_ext;
    product_t s1_b_ext;
    product_t s2_product;
    thread_t  stage_thread [MUL_STAGES-1];

    assign config_match = (config_addr == MUL_CONFIG_ADDR);

    // The thread whose slot just ended, wraps from 0 back to the last thread
    assign read_thread = thread - thread_t'(1);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                a_store[i]      <= '0;
                b_store[i]      <= '0;
                signed_store[i] <= 1'b0;
            end
        end else begin
            if (a_wren) begin
                a_store[thread] <= a;
            end
            if (b_wren) begin
                b_store[thread] <= b;
            end
            if (config_match) begin
                signed_store[thread] <= config_signed;
            end
        end
    end

    // Sign or zero extend to full product width
    always_comb begin
        if (s1_signed) begin
            s1_a_ext = {{WORD_WIDTH{s1_a[WORD_WIDTH-1]}}, s1_a};
            s1_b_ext = {{WORD_WIDTH{s1_b[WORD_WIDTH-1]}}, s1_b};
        end else begin
            s1_a_ext = {{WORD_WIDTH{1'b0}}, s1_a};
            s1_b_ext = {{WORD_WIDTH{1'b0}}, s1_b};
        end
    end

    // Stage 1 reads the stores, stage 2 multiplies
    always_ff @(posedge clock) begin
        if (rst) begin
            s1_a       <= '0;
            s1_b       <= '0;
            s1_signed  <= 1'b0;
            s2_product <= '0;
            for (int i = 0; i < MUL_STAGES - 1; i++) begin
                stage_thread[i] <= '0;
            end
        end else begin
            s1_a            <= a_store[read_thread];
            s1_b            <= b_store[read_thread];
            s1_signed       <= signed_store[read_thread];
            s2_product      <= s1_a_ext * s1_b_ext;
            stage_thread[0] <= read_thread;
            for (int i = 1; i < MUL_STAGES - 1; i++) begin
                stage_thread[i] <= stage_thread[i-1];
            end
        end
    end

    // Stage 3 writes the split product back to its own thread
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                low_store[i]  <= '0;
                high_store[i] <= '0;
            end
        end else begin
            low_store[stage_thread[MUL_STAGES-2]]  <= s2_product[WORD_WIDTH-1:0];
            high_store[stage_thread[MUL_STAGES-2]] <= s2_product[2*WORD_WIDTH-1:WORD_WIDTH];
        end
    end

    assign r_low  = low_store[thread];
    assign r_high = high_store[thread];

endmodule

// ==== hdl/thread_slot_counter.sv ====
// Thread rotation that runs in lockstep with the CPU.
// Thread 0 owns the first cycle after rst is released.
`timescale 1ns/1ps

module thread_slot_counter (
    input  logic                   clock,
    input  logic                   rst,
    output accel_cfg_pkg::thread_t thread
);

    import accel_cfg_pkg::*;

    // Strict round robin over all threads
    always_ff @(posedge clock) begin
        if (rst) begin
            thread <= '0;
        end else if (thread == thread_t'(THREAD_COUNT - 1)) begin
            thread <= '0;
        end else begin
            thread <= thread + thread_t'(1);
        end
    end

endmodule

// ==== hdl/accel_map_pkg.sv ====
// Write address map seen by the accelerators.
// Address 0 is what the CPU presents on a cycle with no write.

package accel_map_pkg;

    localparam int WRITE_ADDR_WIDTH = 10;

    typedef logic [WRITE_ADDR_WIDTH-1:0] write_addr_t;

    // Writing Rb here sets the multiplier mode of the writing thread
    localparam write_addr_t MUL_CONFIG_ADDR = 10'h3F0;

    localparam write_addr_t NULL_WRITE_ADDR = '0;

endpackage

// ==== hdl/accel_cfg_pkg.sv ====
// Data path and thread geometry shared by both accelerators.
// MUL_STAGES must stay below THREAD_COUNT so that a thread's product is
// written back before that thread's next slot.

package accel_cfg_pkg;

    // ------------------------------------------------------------------
    // Sizes

    localparam int WORD_WIDTH   = 36;
    localparam int THREAD_COUNT = 8;
    localparam int THREAD_WIDTH = $clog2(THREAD_COUNT);

    // Operand read, multiply, result write-back
    localparam int MUL_STAGES   = 3;

    // ------------------------------------------------------------------
    // Vector types

    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [2*WORD_WIDTH-1:0] product_t;
    typedef logic [THREAD_WIDTH-1:0] thread_t;

endpackage
